/* filelist.f */
+incdir+src
src/axi_pkg.sv
src/mmio_pkg.sv
src/sb_pointers.sv
src/sb_storage.sv
src/axi_write_drain.sv
src/mmio_access_fsm.sv
src/mmio_port.sv
testbench/tb_mmio_port.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mmio port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_mmio_port \
    -o sim_tb_mmio_port

# a $fatal in the run gives a nonzero exit status
./obj_dir/sim_tb_mmio_port

/* src/axi_pkg.sv */
`include "mmio_params.svh"

package axi_pkg;

    // shared by the read and write address channels
    typedef struct packed {
        logic [`MMIO_ADDR_W-1:0] addr;
        logic [7:0]              len;  // beats minus one
        logic [2:0]              size; // log2 of bytes per beat
    } ax_req_t;

    // one beat on the write data channel
    typedef struct packed {
        logic [`MMIO_DATA_W-1:0]   data;
        logic [`MMIO_DATA_W/8-1:0] strb;
        logic                      last;
    } w_beat_t;

endpackage

/* src/axi_write_drain.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module axi_write_drain (
    input  logic                clk,
    input  logic                rst,
    input  logic                pending,
    input  mmio_pkg::sb_entry_t head_entry,
    output logic                pop,
    output logic                busy,
    output axi_pkg::ax_req_t    aw,
    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::w_beat_t    w,
    output logic                wvalid,
    input  logic                wready
);

    logic                      aw_left;
    logic                      w_left;
    logic                      done;
    logic [`MMIO_DATA_W-1:0]   w_data_q;
    logic [`MMIO_DATA_W/8-1:0] w_strb_q;
    logic                      w_last_q;

    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;
    assign done    = busy && !aw_left && !w_left; // both channels finish by this edge
    assign pop     = pending && (!busy || done);

    assign w = '{data: w_data_q, strb: w_strb_q, last: w_last_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            w_last_q <= 1'b0;
        end else if (pop) begin
            // both channels raised together
            busy     <= 1'b1;
            awvalid  <= 1'b1;
            wvalid   <= 1'b1;
            w_last_q <= 1'b1; // single beat burst
        end else if (done) begin
            busy     <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            w_last_q <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0; // wait for aw
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            aw       <= '{addr: head_entry.waddr, len: 8'd0, size: {1'b0, head_entry.wsize}};
            w_data_q <= head_entry.wdata;
            w_strb_q <= head_entry.wstrb;
        end
    end

    a_w_stable: assert property (
        @(posedge clk) disable iff (rst) (wvalid && !wready) |=> $stable(w)
    ) else $error("write beat changed under back-pressure");

endmodule

/* src/mmio_access_fsm.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmio_access_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  mmio_pkg::cpu_req_t      req,
    input  logic                    stall_m,
    input  logic                    sb_full,
    input  logic                    sb_busy,
    output logic                    push,
    output mmio_pkg::sb_entry_t     push_entry,
    output logic                    dstall,
    output logic [`MMIO_DATA_W-1:0] rdata,
    output axi_pkg::ax_req_t        ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`MMIO_DATA_W-1:0] r_data,
    input  logic                    rvalid,
    output logic                    rready
);

    mmio_pkg::access_state_t state;
    logic                    write_saved; // current write already in the buffer
    logic                    is_read;
    logic                    is_write;
    logic [`MMIO_DATA_W-1:0] rdata_q;

    assign is_read  = req.en && !req.write;
    assign is_write = req.en && req.write;

    // reads always wait in idle, writes only on a full buffer
    assign dstall = (state == mmio_pkg::ACC_IDLE) ? (is_read || (is_write && sb_full))
                                                  : (state != mmio_pkg::ACC_RESULT);

    assign push = (state == mmio_pkg::ACC_IDLE) && is_write && !sb_full && !write_saved;
    assign push_entry = '{waddr: req.addr, wsize: req.size, wstrb: req.wmask, wdata: req.wdata};

    assign rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mmio_pkg::ACC_IDLE;
            write_saved <= 1'b0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
        end else begin
            if (!dstall && !stall_m) begin
                write_saved <= 1'b0; // pipeline moved on
            end else if (push) begin
                write_saved <= 1'b1;
            end
            case (state)
                mmio_pkg::ACC_IDLE: begin
                    if (is_read && !sb_busy) begin // buffer drained first
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= mmio_pkg::ACC_READ;
                    end
                end
                mmio_pkg::ACC_READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid && rready) begin
                        rready <= 1'b0;
                        state  <= mmio_pkg::ACC_RESULT;
                    end
                end
                mmio_pkg::ACC_RESULT: begin
                    if (!stall_m) begin
                        state <= mmio_pkg::ACC_IDLE;
                    end
                end
                default: state <= mmio_pkg::ACC_IDLE;
            endcase
        end
    end

    // read payload and result
    always_ff @(posedge clk) begin
        if (state == mmio_pkg::ACC_IDLE && is_read && !sb_busy) begin
            ar <= '{addr: req.addr, len: 8'd0, size: {1'b0, req.size}};
        end
        if (state == mmio_pkg::ACC_READ && rvalid && rready) begin
            rdata_q <= r_data;
        end
    end

    a_ar_in_read: assert property (
        @(posedge clk) disable iff (rst) arvalid |-> state == mmio_pkg::ACC_READ
    ) else $error("arvalid outside of read state");

endmodule

/* src/mmio_params.svh */
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// bus widths
`define MMIO_ADDR_W 32
`define MMIO_DATA_W 32

// store buffer, depth must stay a power of two
`define MMIO_SB_DEPTH 8
`define MMIO_SB_PTR_W 3

`endif

/* src/mmio_pkg.sv */
`include "mmio_params.svh"

package mmio_pkg;

    // memory stage request from the pipeline
    typedef struct packed {
        logic                      en;
        logic                      write;
        logic [`MMIO_ADDR_W-1:0]   addr;
        logic [1:0]                size;
        logic [`MMIO_DATA_W/8-1:0] wmask;
        logic [`MMIO_DATA_W-1:0]   wdata;
    } cpu_req_t;

    // one buffered uncached store
    typedef struct packed {
        logic [`MMIO_ADDR_W-1:0]   waddr;
        logic [1:0]                wsize;
        logic [`MMIO_DATA_W/8-1:0] wstrb;
        logic [`MMIO_DATA_W-1:0]   wdata; // already lane aligned
    } sb_entry_t;

    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_READ,
        ACC_RESULT
    } access_state_t;

endpackage

/* src/mmio_port.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmio_port (
    input  logic                    clk,
    input  logic                    rst,
    input  mmio_pkg::cpu_req_t      req,
    input  logic                    stall_m,
    output logic                    dstall,
    output logic [`MMIO_DATA_W-1:0] rdata,
    output axi_pkg::ax_req_t        ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`MMIO_DATA_W-1:0] r_data,
    input  logic                    rvalid,
    input  logic                    rlast,
    output logic                    rready,
    output axi_pkg::ax_req_t        aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_pkg::w_beat_t        w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);

    logic                      push;
    logic                      pop;
    mmio_pkg::sb_entry_t       push_entry;
    mmio_pkg::sb_entry_t       head_entry;
    logic [`MMIO_SB_PTR_W-1:0] head;
    logic [`MMIO_SB_PTR_W-1:0] tail;
    logic                      sb_full;
    logic                      sb_pending;
    logic                      drain_busy;
    logic                      sb_busy;

    assign sb_busy = sb_pending || drain_busy; // holds reads back
    assign bready  = 1'b1; // write responses carry nothing we use

    mmio_access_fsm i_fsm (
        .clk, .rst, .req, .stall_m, .sb_full, .sb_busy, .push, .push_entry,
        .dstall, .rdata, .ar, .arvalid, .arready, .r_data, .rvalid, .rready
    );

    sb_pointers i_ptrs (
        .clk, .rst, .push, .pop, .head, .tail, .full(sb_full), .pending(sb_pending)
    );

    sb_storage i_store (
        .clk, .we(push), .waddr_idx(tail), .raddr_idx(head),
        .wentry(push_entry), .rentry(head_entry)
    );

    axi_write_drain i_drain (
        .clk, .rst, .pending(sb_pending), .head_entry, .pop, .busy(drain_busy),
        .aw, .awvalid, .awready, .w, .wvalid, .wready
    );

    // single beat reads, and no response may arrive with nothing in flight on the bus
    a_read_single_beat: assert property (
        @(posedge clk) disable iff (rst) (rvalid && rready) |-> rlast
    ) else $error("read burst longer than one beat");

    a_bresp_after_write: assert property (
        @(posedge clk) disable iff (rst) bvalid |-> $past(drain_busy) || drain_busy
    ) else $error("write response without a write in flight");

endmodule

/* src/sb_pointers.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module sb_pointers (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  logic                      pop,
    output logic [`MMIO_SB_PTR_W-1:0] head,
    output logic [`MMIO_SB_PTR_W-1:0] tail,
    output logic                      full,
    output logic                      pending
);

    logic [`MMIO_SB_PTR_W-1:0] tail_next;

    assign tail_next = tail + 1'b1; // wraps on power of two depth
    assign pending   = head != tail;
    assign full      = tail_next == head; // one slot kept empty

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail_next;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // the FSM and the drain must honour the flags
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("store buffer push while full");

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> pending
    ) else $error("store buffer pop while empty");

endmodule

/* src/sb_storage.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module sb_storage (
    input  logic                      clk,
    input  logic                      we,
    input  logic [`MMIO_SB_PTR_W-1:0] waddr_idx,
    input  logic [`MMIO_SB_PTR_W-1:0] raddr_idx,
    input  mmio_pkg::sb_entry_t       wentry,
    output mmio_pkg::sb_entry_t       rentry
);

    mmio_pkg::sb_entry_t entries [`MMIO_SB_DEPTH];

    // written at tail
    always_ff @(posedge clk) begin
        if (we) begin
            entries[waddr_idx] <= wentry;
        end
    end

    // head entry visible in the same cycle
    assign rentry = entries[raddr_idx];

endmodule

/* testbench/tb_mmio_port.sv */
`timescale 1ns/1ps

module tb_mmio_port;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] READ_XOR = 32'hA5A5_0000;

    logic                clk;
    logic                rst;
    mmio_pkg::cpu_req_t  req;
    logic                stall_m;
    logic                dstall;
    logic [31:0]         rdata;
    axi_pkg::ax_req_t    ar;
    logic                arvalid;
    logic                arready;
    logic [31:0]         r_data;
    logic                rvalid;
    logic                rlast;
    logic                rready;
    axi_pkg::ax_req_t    aw;
    logic                awvalid;
    logic                awready;
    axi_pkg::w_beat_t    w;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;

    // responder settings and bookkeeping
    int unsigned         bp_pct = 0;      // percent of cycles with ready low
    int unsigned         hold_cycles = 0; // wready forced low while nonzero
    int unsigned         reads_done = 0;
    int unsigned         read_delay;
    logic                read_wait;
    logic [31:0]         read_addr;
    logic                aw_ok;
    logic                w_ok;
    logic                ar_ok;
    int unsigned         cycles = 0;
    axi_pkg::ax_req_t    aw_q[$];
    axi_pkg::w_beat_t    w_q[$];
    axi_pkg::ax_req_t    ar_q[$];
    mmio_pkg::sb_entry_t exp_q[$];

    mmio_port i_mmio_port (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic draw_ready();
        return (bp_pct == 0) || ($urandom_range(99) >= bp_pct);
    endfunction

    // bus responder picks ready at the falling edge for the next rising edge
    initial begin
        awready   = 1'b0;
        wready    = 1'b0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        r_data    = '0;
        bvalid    = 1'b0; // responses are ignored by the port
        read_wait = 1'b0;
        forever begin
            @(negedge clk);
            aw_ok = draw_ready();
            w_ok  = draw_ready() && (hold_cycles == 0);
            ar_ok = draw_ready();
            if (hold_cycles > 0) hold_cycles--;
            if (awvalid && aw_ok) aw_q.push_back(aw);
            if (wvalid && w_ok) w_q.push_back(w);
            if (rvalid) begin // taken at the last edge since rready stays high
                rvalid = 1'b0;
                rlast  = 1'b0;
                reads_done++;
            end else if (read_wait) begin
                if (read_delay == 0) begin
                    rvalid    = 1'b1;
                    rlast     = 1'b1;
                    r_data    = read_addr ^ READ_XOR;
                    read_wait = 1'b0;
                end else begin
                    read_delay--;
                end
            end
            if (arvalid && ar_ok) begin
                ar_q.push_back(ar);
                read_addr  = ar.addr;
                read_delay = $urandom_range(5);
                read_wait  = 1'b1;
            end
            awready = aw_ok;
            wready  = w_ok;
            arready = ar_ok;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // starts at a falling edge and returns at the falling edge after acceptance
    task automatic cpu_write(input logic [31:0] addr, input logic [1:0] size,
                             input logic [3:0] mask, input logic [31:0] data,
                             output logic stalled);
        req = '{en: 1'b1, write: 1'b1, addr: addr, size: size, wmask: mask, wdata: data};
        exp_q.push_back('{waddr: addr, wsize: size, wstrb: mask, wdata: data});
        #1;
        stalled = dstall;
        while (dstall) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req.en = 1'b0;
    endtask

    task automatic wait_beats(input int n);
        while (w_q.size() < n || aw_q.size() < n) @(negedge clk);
        repeat (4) @(negedge clk); // room for a stray extra beat
    endtask

    task automatic compare_beats(input string name);
        mmio_pkg::sb_entry_t e;
        axi_pkg::ax_req_t    a;
        axi_pkg::w_beat_t    b;
        check_equal({name, " aw count"}, 32'(exp_q.size()), 32'(aw_q.size()));
        check_equal({name, " w count"}, 32'(exp_q.size()), 32'(w_q.size()));
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            a = aw_q.pop_front();
            b = w_q.pop_front();
            check_equal({name, " addr"}, e.waddr, a.addr);
            check_equal({name, " len"}, 32'd0, 32'(a.len));
            check_equal({name, " size"}, 32'({1'b0, e.wsize}), 32'(a.size));
            check_equal({name, " data"}, e.wdata, b.data);
            check_equal({name, " strb"}, 32'(e.wstrb), 32'(b.strb));
            check_equal({name, " last"}, 32'd1, 32'(b.last));
        end
    endtask

    task automatic test_reset_state();
        #1;
        check_equal("reset_state arvalid", 32'd0, 32'(arvalid));
        check_equal("reset_state awvalid", 32'd0, 32'(awvalid));
        check_equal("reset_state wvalid", 32'd0, 32'(wvalid));
        check_equal("reset_state rready", 32'd0, 32'(rready));
        check_equal("reset_state dstall", 32'd0, 32'(dstall));
        check_equal("reset_state bready", 32'd1, 32'(bready));
    endtask

    task automatic test_single_write();
        logic stalled;
        bp_pct = 0;
        @(negedge clk);
        cpu_write(32'h1000_0010, 2'd2, 4'hF, 32'hDEAD_BEEF, stalled);
        #1;
        check_equal("single_write first edge awvalid", 32'd0, 32'(awvalid));
        check_equal("single_write first edge wvalid", 32'd0, 32'(wvalid));
        @(negedge clk);
        #1;
        check_equal("single_write second edge awvalid", 32'd1, 32'(awvalid));
        check_equal("single_write second edge wvalid", 32'd1, 32'(wvalid));
        wait_beats(1);
        compare_beats("single_write");
    endtask

    task automatic test_ordered_writes();
        int unsigned i;
        logic        stalled;
        bp_pct = 50;
        @(negedge clk);
        for (i = 0; i < 20; i++) begin
            cpu_write($urandom & 32'hFFFF_FFFC, 2'($urandom_range(2)), 4'($urandom),
                      $urandom, stalled);
        end
        wait_beats(20);
        compare_beats("ordered_writes");
        // seven entries fit the buffer, one more sits on the bus
        bp_pct = 0;
        hold_cycles = 30;
        for (i = 0; i < 9; i++) begin
            cpu_write($urandom & 32'hFFFF_FFFC, 2'd2, 4'hF, $urandom, stalled);
            check_equal("wready_hold dstall", 32'(i == 8), 32'(stalled));
        end
        wait_beats(9);
        compare_beats("wready_hold");
    endtask

    task automatic test_stalled_write();
        bp_pct = 0;
        @(negedge clk);
        req = '{en: 1'b1, write: 1'b1, addr: 32'h2000_0004, size: 2'd1, wmask: 4'h3,
                wdata: 32'h0000_5A5A};
        exp_q.push_back('{waddr: 32'h2000_0004, wsize: 2'd1, wstrb: 4'h3, wdata: 32'h0000_5A5A});
        stall_m = 1'b1;
        repeat (5) @(negedge clk);
        stall_m = 1'b0;
        @(negedge clk);
        req.en = 1'b0;
        wait_beats(1);
        compare_beats("stalled_write");
    endtask

    task automatic test_read_result();
        logic [31:0]      addr;
        int unsigned      start;
        axi_pkg::ax_req_t a;
        bp_pct = 50;
        addr = $urandom & 32'hFFFF_FFFC;
        start = reads_done;
        ar_q.delete();
        @(negedge clk);
        req = '{en: 1'b1, write: 1'b0, addr: addr, size: 2'd2, wmask: '0, wdata: '0};
        stall_m = 1'b1; // later stage holds the pipeline
        #1;
        while (dstall) begin
            check_equal("read_result stall before data", start, reads_done);
            @(negedge clk);
            #1;
        end
        check_equal("read_result reads", start + 1, reads_done);
        check_equal("read_result ar count", 32'd1, 32'(ar_q.size()));
        a = ar_q.pop_front();
        check_equal("read_result ar addr", addr, a.addr);
        check_equal("read_result ar len", 32'd0, 32'(a.len));
        check_equal("read_result ar size", 32'd2, 32'(a.size));
        repeat (3) begin
            check_equal("read_result rdata", addr ^ READ_XOR, rdata);
            check_equal("read_result dstall", 32'd0, 32'(dstall));
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        stall_m = 1'b0;
        @(negedge clk);
        req.en = 1'b0;
    endtask

    task automatic test_read_after_writes();
        int unsigned i;
        logic        stalled;
        logic [31:0] addr;
        bp_pct = 50;
        addr = $urandom & 32'hFFFF_FFFC;
        @(negedge clk);
        for (i = 0; i < 4; i++) begin
            cpu_write($urandom & 32'hFFFF_FFFC, 2'd2, 4'($urandom), $urandom, stalled);
        end
        req = '{en: 1'b1, write: 1'b0, addr: addr, size: 2'd2, wmask: '0, wdata: '0};
        #1;
        while (!arvalid) begin
            @(negedge clk);
            #1;
        end
        check_equal("read_after_writes w beats", 32'd4, 32'(w_q.size()));
        check_equal("read_after_writes aw beats", 32'd4, 32'(aw_q.size()));
        while (dstall) begin
            @(negedge clk);
            #1;
        end
        check_equal("read_after_writes rdata", addr ^ READ_XOR, rdata);
        @(negedge clk);
        req.en = 1'b0;
        wait_beats(4);
        compare_beats("read_after_writes");
    endtask

    initial begin
        void'($urandom(43));
        rst = 1'b1;
        req = '0;
        stall_m = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single_write();
        test_ordered_writes();
        test_stalled_write();
        test_read_result();
        test_read_after_writes();
        $display("Everything OK");
        $finish;
    end

endmodule
